//--- include/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// ==================================================
// Bus widths
// ==================================================
`define MEM_DATA_W 32
`define MEM_ADDR_W 32
// One select per byte lane
`define MEM_SEL_W 4

// ==================================================
// Memory map
// ==================================================
// Data RAM, word addressed inside
`define RAM_BASE 32'h1000_0000
`define RAM_BYTES 1024
// GPIO block, out reg at +0, in reg at +4
`define GPIO_BASE 32'hFFFF_FFF8
`define GPIO_BYTES 8
`define GPIO_W 32

`endif

//--- design/mem_bus_pkg.sv
`include "mem_params.svh"

package mem_bus_pkg;

    // ==================================================
    // Shared bus request, driven by a master
    // ==================================================
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        // Byte lane enables
        logic [`MEM_SEL_W-1:0]  sel;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;
    } bus_req_t;

    // Slave answer, all zero when idle so answers merge by OR
    typedef struct packed {
        logic                   ack;
        logic                   err;
        logic [`MEM_DATA_W-1:0] data;
    } bus_rsp_t;

    // Granted master, 0 is the CPU side
    typedef logic [0:0] master_idx_t;

endpackage

//--- design/mem_access_pkg.sv
`include "mem_params.svh"

package mem_access_pkg;

    // ==================================================
    // CPU load/store view
    // ==================================================
    // Access width
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // Held by the CPU until the one-cycle ack
    typedef struct packed {
        logic                   we;
        access_size_e           size;
        // Zero extend on loads when set
        logic                   is_unsigned;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } cpu_req_t;

endpackage

//--- design/data_bus_master.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module data_bus_master (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_cpu_req,
    input  mem_access_pkg::cpu_req_t i_cpu,
    output logic                     o_cpu_ack,
    output logic                     o_cpu_err,
    output logic [`MEM_DATA_W-1:0]   o_cpu_rdata,
    output mem_bus_pkg::bus_req_t    o_bus,
    input  mem_bus_pkg::bus_rsp_t    i_bus
);

    mem_bus_pkg::bus_req_t        bus_q;
    // Saved at accept, used to realign read data
    mem_access_pkg::access_size_e size_q;
    logic                         unsigned_q;
    logic [1:0]                   off_q;
    logic [`MEM_SEL_W-1:0]        sel_d;
    logic [`MEM_DATA_W-1:0]       rd_shift;
    logic                         busy;
    logic                         done;

    assign busy = bus_q.cyc;
    // Cycle ends on either answer
    assign done = busy && (i_bus.ack || i_bus.err);

    // ==================================================
    // Request side
    // ==================================================
    // Lane enables from size and low address bits
    always_comb begin
        case (i_cpu.size)
            mem_access_pkg::SIZE_BYTE: sel_d = 4'b0001 << i_cpu.addr[1:0];
            mem_access_pkg::SIZE_HALF: sel_d = 4'b0011 << {i_cpu.addr[1], 1'b0};
            default:                   sel_d = 4'b1111;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bus_q.cyc <= 1'b0;
            bus_q.stb <= 1'b0;
        end else if (done) begin
            // Drop cyc for at least the next cycle
            bus_q.cyc <= 1'b0;
            bus_q.stb <= 1'b0;
        end else if (!busy && i_cpu_req) begin
            bus_q.cyc  <= 1'b1;
            bus_q.stb  <= 1'b1;
            bus_q.we   <= i_cpu.we;
            bus_q.sel  <= sel_d;
            bus_q.addr <= i_cpu.addr;
            // Move store data into its lanes
            bus_q.data <= i_cpu.wdata << {i_cpu.addr[1:0], 3'b000};
            size_q     <= i_cpu.size;
            unsigned_q <= i_cpu.is_unsigned;
            off_q      <= i_cpu.addr[1:0];
        end
    end

    assign o_bus = bus_q;

    // ==================================================
    // Response side
    // ==================================================
    assign o_cpu_ack = busy && i_bus.ack;
    assign o_cpu_err = busy && i_bus.err;

    // Bring the addressed lane down to bit 0
    assign rd_shift = i_bus.data >> {off_q, 3'b000};

    always_comb begin
        o_cpu_rdata = '0;
        if (o_cpu_ack) begin
            case (size_q)
                mem_access_pkg::SIZE_BYTE:
                    o_cpu_rdata = {{24{rd_shift[7] & ~unsigned_q}}, rd_shift[7:0]};
                mem_access_pkg::SIZE_HALF:
                    o_cpu_rdata = {{16{rd_shift[15] & ~unsigned_q}}, rd_shift[15:0]};
                default:
                    o_cpu_rdata = rd_shift;
            endcase
        end
    end

    // CPU keeps fields steady until it sees the ack
    a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cpu_req && !o_cpu_ack && !o_cpu_err) |=> $stable(i_cpu));

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // Master 0 is the CPU, master 1 the DMA
    input  mem_bus_pkg::bus_req_t i_m0,
    input  mem_bus_pkg::bus_req_t i_m1,
    output mem_bus_pkg::bus_rsp_t o_m0,
    output mem_bus_pkg::bus_rsp_t o_m1,
    // Single slave side
    output mem_bus_pkg::bus_req_t o_s,
    input  mem_bus_pkg::bus_rsp_t i_s
);

    logic                     grant_valid;
    mem_bus_pkg::master_idx_t grant_idx;
    logic                     slv_done;

    assign slv_done = i_s.ack || i_s.err;

    // ==================================================
    // Grant register
    // ==================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_valid <= 1'b0;
            grant_idx   <= 1'b0;
        end else if (!grant_valid) begin
            // Fixed priority on an idle bus
            if (i_m0.cyc) begin
                grant_valid <= 1'b1;
                grant_idx   <= 1'b0;
            end else if (i_m1.cyc) begin
                grant_valid <= 1'b1;
                grant_idx   <= 1'b1;
            end
        end else if (slv_done) begin
            grant_valid <= 1'b0;
        end
    end

    // Forward only the owner, everything else reads as idle
    always_comb begin
        o_s = '0;
        if (grant_valid) begin
            o_s = grant_idx ? i_m1 : i_m0;
        end
    end

    // Answers go back to the owner only
    assign o_m0 = (grant_valid && grant_idx == 1'b0) ? i_s : '0;
    assign o_m1 = (grant_valid && grant_idx == 1'b1) ? i_s : '0;

    // Slaves only ever answer a granted cycle, so no answer is lost
    a_rsp_has_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        slv_done |-> grant_valid);

endmodule

//--- design/bus_decoder.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module bus_decoder (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mem_bus_pkg::bus_req_t i_s,
    output mem_bus_pkg::bus_rsp_t o_s,
    output mem_bus_pkg::bus_req_t o_ram_req,
    output mem_bus_pkg::bus_req_t o_gpio_req,
    input  mem_bus_pkg::bus_rsp_t i_ram_rsp,
    input  mem_bus_pkg::bus_rsp_t i_gpio_rsp
);

    // ==================================================
    // Region compare on the upper address bits
    // ==================================================
    localparam int RAM_AW  = $clog2(`RAM_BYTES);
    localparam int GPIO_AW = $clog2(`GPIO_BYTES);
    localparam logic [`MEM_ADDR_W-1:0] RAM_BASE_A  = `RAM_BASE;
    localparam logic [`MEM_ADDR_W-1:0] GPIO_BASE_A = `GPIO_BASE;

    logic hit_ram;
    logic hit_gpio;
    logic unmapped;
    logic err_q;

    assign hit_ram  = i_s.addr[`MEM_ADDR_W-1:RAM_AW] == RAM_BASE_A[`MEM_ADDR_W-1:RAM_AW];
    assign hit_gpio = i_s.addr[`MEM_ADDR_W-1:GPIO_AW] == GPIO_BASE_A[`MEM_ADDR_W-1:GPIO_AW];
    assign unmapped = i_s.cyc && i_s.stb && !hit_ram && !hit_gpio;

    // Same fields to both, strobes to the match only
    always_comb begin
        o_ram_req      = i_s;
        o_ram_req.cyc  = i_s.cyc && hit_ram;
        o_ram_req.stb  = i_s.stb && hit_ram;
        o_gpio_req     = i_s;
        o_gpio_req.cyc = i_s.cyc && hit_gpio;
        o_gpio_req.stb = i_s.stb && hit_gpio;
    end

    // Own error for no match, one pulse per cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped && !err_q;
        end
    end

    // Idle slaves drive zero
    assign o_s.ack  = i_ram_rsp.ack | i_gpio_rsp.ack;
    assign o_s.err  = i_ram_rsp.err | i_gpio_rsp.err | err_q;
    assign o_s.data = i_ram_rsp.data | i_gpio_rsp.data;

    // One answer at most reaches the OR merge
    a_one_answer: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0({i_ram_rsp.ack | i_ram_rsp.err, i_gpio_rsp.ack | i_gpio_rsp.err, err_q}));

endmodule

//--- design/data_ram.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module data_ram (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mem_bus_pkg::bus_req_t i_req,
    output mem_bus_pkg::bus_rsp_t o_rsp
);

    localparam int WORDS = `RAM_BYTES / 4;
    localparam int IDX_W = $clog2(WORDS);

    logic [`MEM_DATA_W-1:0] mem [WORDS];
    logic [`MEM_DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]       idx;
    logic                   ack_q;
    logic                   accept;

    // Byte address down to word index
    assign idx = i_req.addr[IDX_W+1:2];
    // Strobe stays up during the ack cycle, take it once
    assign accept = i_req.cyc && i_req.stb && !ack_q;

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge i_clk) begin
        if (accept) begin
            rdata_q <= mem[idx];
            if (i_req.we) begin
                for (int i = 0; i < `MEM_SEL_W; i++) begin
                    if (i_req.sel[i]) begin
                        mem[idx][8*i +: 8] <= i_req.data[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // Zero when idle for the OR merge
    assign o_rsp.ack  = ack_q;
    assign o_rsp.err  = 1'b0;
    assign o_rsp.data = ack_q ? rdata_q : '0;

endmodule

//--- design/gpio_regs.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module gpio_regs (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  mem_bus_pkg::bus_req_t i_req,
    output mem_bus_pkg::bus_rsp_t o_rsp,
    input  logic [`GPIO_W-1:0]    i_gpio,
    output logic [`GPIO_W-1:0]    o_gpio
);

    logic [`GPIO_W-1:0]     out_q;
    logic [`GPIO_W-1:0]     in_q;
    logic [`MEM_DATA_W-1:0] rdata_q;
    logic                   ack_q;
    logic                   err_q;
    logic                   accept;
    logic                   bad_wr;

    assign accept = i_req.cyc && i_req.stb && !ack_q && !err_q;
    // Offset 4 is the input reg, read only
    assign bad_wr = i_req.we && i_req.addr[2];

    // Pins sampled every cycle
    always_ff @(posedge i_clk) begin
        in_q <= i_gpio;
        if (accept) begin
            rdata_q <= i_req.addr[2] ? in_q : out_q;
        end
    end

    // ==================================================
    // Output reg and handshake
    // ==================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_q <= '0;
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= accept && !bad_wr;
            err_q <= accept && bad_wr;
            if (accept && i_req.we && !i_req.addr[2]) begin
                for (int i = 0; i < `MEM_SEL_W; i++) begin
                    if (i_req.sel[i]) begin
                        out_q[8*i +: 8] <= i_req.data[8*i +: 8];
                    end
                end
            end
        end
    end

    assign o_gpio     = out_q;
    assign o_rsp.ack  = ack_q;
    assign o_rsp.err  = err_q;
    assign o_rsp.data = ack_q ? rdata_q : '0;

endmodule

//--- design/mem_stage_top.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module mem_stage_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    // CPU load/store port
    input  logic                     i_cpu_req,
    input  mem_access_pkg::cpu_req_t i_cpu,
    output logic                     o_cpu_ack,
    output logic                     o_cpu_err,
    output logic [`MEM_DATA_W-1:0]   o_cpu_rdata,
    // DMA port, raw bus master
    input  mem_bus_pkg::bus_req_t    i_dma,
    output mem_bus_pkg::bus_rsp_t    o_dma,
    // Pins
    input  logic [`GPIO_W-1:0]       i_gpio,
    output logic [`GPIO_W-1:0]       o_gpio
);

    // CPU master to arbiter
    mem_bus_pkg::bus_req_t cpu_bus_req;
    mem_bus_pkg::bus_rsp_t cpu_bus_rsp;
    // Arbiter to decoder
    mem_bus_pkg::bus_req_t slv_req;
    mem_bus_pkg::bus_rsp_t slv_rsp;
    // Decoder to slaves
    mem_bus_pkg::bus_req_t ram_req;
    mem_bus_pkg::bus_rsp_t ram_rsp;
    mem_bus_pkg::bus_req_t gpio_req;
    mem_bus_pkg::bus_rsp_t gpio_rsp;

    // ==================================================
    // Masters and arbitration
    // ==================================================
    data_bus_master u_master (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cpu_req   (i_cpu_req),
        .i_cpu       (i_cpu),
        .o_cpu_ack   (o_cpu_ack),
        .o_cpu_err   (o_cpu_err),
        .o_cpu_rdata (o_cpu_rdata),
        .o_bus       (cpu_bus_req),
        .i_bus       (cpu_bus_rsp)
    );

    // Port 0 wins ties, keep the CPU there
    bus_arbiter u_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_m0    (cpu_bus_req),
        .i_m1    (i_dma),
        .o_m0    (cpu_bus_rsp),
        .o_m1    (o_dma),
        .o_s     (slv_req),
        .i_s     (slv_rsp)
    );

    // ==================================================
    // Address decode and slaves
    // ==================================================
    bus_decoder u_dec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_s        (slv_req),
        .o_s        (slv_rsp),
        .o_ram_req  (ram_req),
        .o_gpio_req (gpio_req),
        .i_ram_rsp  (ram_rsp),
        .i_gpio_rsp (gpio_rsp)
    );

    data_ram u_ram (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (ram_req),
        .o_rsp   (ram_rsp)
    );

    gpio_regs u_gpio (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (gpio_req),
        .o_rsp   (gpio_rsp),
        .i_gpio  (i_gpio),
        .o_gpio  (o_gpio)
    );

endmodule

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_params.svh"

module mem_stage_tb;

    localparam int MAX_PAT = 64;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     i_cpu_req;
    mem_access_pkg::cpu_req_t i_cpu;
    logic                     o_cpu_ack;
    logic                     o_cpu_err;
    logic [`MEM_DATA_W-1:0]   o_cpu_rdata;
    mem_bus_pkg::bus_req_t    i_dma;
    mem_bus_pkg::bus_rsp_t    o_dma;
    logic [`GPIO_W-1:0]       i_gpio;
    logic [`GPIO_W-1:0]       o_gpio;

    // Pattern table, one entry per access
    logic                   pat_dma   [MAX_PAT];
    logic                   pat_we    [MAX_PAT];
    logic [1:0]             pat_size  [MAX_PAT];
    logic                   pat_uns   [MAX_PAT];
    logic [`MEM_ADDR_W-1:0] pat_addr  [MAX_PAT];
    logic [`MEM_DATA_W-1:0] pat_wdata [MAX_PAT];
    logic [`MEM_DATA_W-1:0] pat_rdata [MAX_PAT];
    logic                   pat_pins  [MAX_PAT];
    logic                   pat_err   [MAX_PAT];
    int                     n_pat;
    int                     idx;
    int                     errors;
    int                     checks;
    int                     cycles;
    int                     seed;

    mem_stage_top dut0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cpu_req   (i_cpu_req),
        .i_cpu       (i_cpu),
        .o_cpu_ack   (o_cpu_ack),
        .o_cpu_err   (o_cpu_err),
        .o_cpu_rdata (o_cpu_rdata),
        .i_dma       (i_dma),
        .o_dma       (o_dma),
        .i_gpio      (i_gpio),
        .o_gpio      (o_gpio)
    );

    // 8 ns clock
    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // ==================================================
    // Checks and pattern loading
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          we;
        int          size;
        int          uns;
        int          err;
        string       line;
        logic [23:0] port_s;
        logic [31:0] exp_s;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        pins;
        fd = $fopen("dv/mem_stage_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/mem_stage_patterns.txt");
        end else begin
            while (!$feof(fd) && n_pat < MAX_PAT) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (line.len() > 1 && line[0] != "#") begin
                    rdata = '0;
                    pins  = 1'b0;
                    n = $sscanf(line, "%s %d %d %d %h %h %h %d",
                                port_s, we, size, uns, addr, wdata, rdata, err);
                    // Expected data may be the pin keyword instead of hex
                    if (n != 8) begin
                        n = $sscanf(line, "%s %d %d %d %h %h %s %d",
                                    port_s, we, size, uns, addr, wdata, exp_s, err);
                        pins = (n == 8) && (exp_s == "pins");
                    end
                    if (n != 8 || (port_s != "cpu" && port_s != "dma")) begin
                        errors++;
                        $display("Pattern line could not be read: %s", line);
                    end else begin
                        pat_dma[n_pat]   = (port_s == "dma");
                        pat_we[n_pat]    = we[0];
                        pat_size[n_pat]  = size[1:0];
                        pat_uns[n_pat]   = uns[0];
                        pat_addr[n_pat]  = addr;
                        pat_wdata[n_pat] = wdata;
                        pat_rdata[n_pat] = rdata;
                        pat_pins[n_pat]  = pins;
                        pat_err[n_pat]   = err[0];
                        n_pat++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ==================================================
    // Port drivers
    // ==================================================
    task automatic start_cpu(input int i);
        i_cpu_req         = 1'b1;
        i_cpu.we          = pat_we[i];
        i_cpu.size        = mem_access_pkg::access_size_e'(pat_size[i]);
        i_cpu.is_unsigned = pat_uns[i];
        i_cpu.addr        = pat_addr[i];
        i_cpu.wdata       = pat_wdata[i];
        // New pin value, sampled long before the GPIO read
        i_gpio            = $random(seed);
    endtask

    // DMA lines are word accesses
    task automatic start_dma(input int i);
        i_dma.cyc  = 1'b1;
        i_dma.stb  = 1'b1;
        i_dma.we   = pat_we[i];
        i_dma.sel  = '1;
        i_dma.addr = pat_addr[i];
        i_dma.data = pat_wdata[i];
    endtask

    task automatic check_cpu(input int i);
        if (!pat_we[i]) begin
            check_value("o_cpu_rdata", o_cpu_rdata, pat_pins[i] ? i_gpio : pat_rdata[i]);
        end
        check_value("o_cpu_err", 32'(o_cpu_err), 32'(pat_err[i]));
        // Output register write shows on the pins by the ack cycle
        if (pat_we[i] && !pat_err[i] && pat_addr[i] == `GPIO_BASE) begin
            check_value("o_gpio", o_gpio, pat_wdata[i]);
        end
    endtask

    task automatic check_dma(input int i);
        if (!pat_we[i]) begin
            check_value("o_dma.data", o_dma.data, pat_rdata[i]);
        end
        check_value("o_dma.err", 32'(o_dma.err), 32'(pat_err[i]));
    endtask

    // CPU access, DMA access or both, a negative index skips that port
    task automatic run_access(input int ci, input int di);
        logic cpu_busy;
        logic dma_busy;
        logic dma_wait;
        cpu_busy = (ci >= 0);
        dma_busy = (di >= 0);
        // Master registers its cyc, so DMA goes up one cycle later to meet it
        dma_wait = cpu_busy && dma_busy;
        @(negedge i_clk);
        if (cpu_busy) begin
            start_cpu(ci);
        end
        if (dma_busy && !dma_wait) begin
            start_dma(di);
        end
        while (cpu_busy || dma_busy) begin
            @(negedge i_clk);
            if (dma_wait) begin
                start_dma(di);
                dma_wait = 1'b0;
            end
            if (cpu_busy && (o_cpu_ack || o_cpu_err)) begin
                check_cpu(ci);
                i_cpu_req = 1'b0;
                cpu_busy  = 1'b0;
            end
            if (dma_busy && (o_dma.ack || o_dma.err)) begin
                check_dma(di);
                i_dma    = '0;
                dma_busy = 1'b0;
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        seed      = 74545;
        errors    = 0;
        checks    = 0;
        i_rst_n   = 1'b0;
        i_cpu_req = 1'b0;
        i_cpu     = '0;
        i_dma     = '0;
        i_gpio    = $random(seed);
        load_patterns();
        // Two rising edges in reset, release on the next falling edge
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        if (n_pat == 0) begin
            errors++;
            $display("No patterns were loaded, nothing was run");
        end
        idx = 0;
        while (idx < n_pat) begin
            // A DMA line followed by a CPU line runs as a contending pair
            if (pat_dma[idx] && idx + 1 < n_pat && !pat_dma[idx + 1]) begin
                run_access(idx + 1, idx);
                idx += 2;
            end else if (pat_dma[idx]) begin
                run_access(-1, idx);
                idx++;
            end else begin
                run_access(idx, -1);
                idx++;
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Hang guard, 40 cycles per access plus setup
    initial begin
        cycles = 0;
        wait (n_pat > 0);
        while (cycles < 40 * n_pat + 50) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, an access never got its ack or err", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- mem_stage_top.f
+incdir+include
design/mem_bus_pkg.sv
design/mem_access_pkg.sv
design/data_bus_master.sv
design/bus_arbiter.sv
design/bus_decoder.sv
design/data_ram.sv
design/gpio_regs.sv
design/mem_stage_top.sv
dv/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module mem_stage_tb -f mem_stage_top.f

out=$(./obj_dir/Vmem_stage_tb)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$"

//--- dv/mem_stage_patterns.txt
# port we size(0 byte,1 half,2 word) unsigned addr wdata exp_rdata exp_err
# exp_rdata is ignored on writes, pins means the current i_gpio value
cpu 1 2 0 10000000 11223344 00000000 0
cpu 1 2 0 10000004 a5b6c7d8 00000000 0
cpu 0 2 0 10000000 00000000 11223344 0
cpu 0 2 0 10000004 00000000 a5b6c7d8 0
cpu 1 0 0 10000001 000000ee 00000000 0
cpu 1 1 0 10000006 0000beef 00000000 0
cpu 0 2 0 10000000 00000000 1122ee44 0
cpu 0 2 0 10000004 00000000 beefc7d8 0
cpu 0 0 0 10000001 00000000 ffffffee 0
cpu 0 0 1 10000001 00000000 000000ee 0
cpu 0 1 0 10000006 00000000 ffffbeef 0
cpu 0 1 1 10000006 00000000 0000beef 0
cpu 0 0 0 10000003 00000000 00000011 0
cpu 0 2 0 20000000 00000000 00000000 1
cpu 1 2 0 20000000 deadbeef 00000000 1
cpu 1 2 0 fffffff8 cafef00d 00000000 0
cpu 0 2 0 fffffff8 00000000 cafef00d 0
cpu 0 2 0 fffffffc 00000000 pins 0
cpu 1 2 0 fffffffc 12345678 00000000 1
cpu 0 2 0 fffffff8 00000000 cafef00d 0
cpu 0 2 0 10000000 00000000 1122ee44 0
dma 1 2 0 10000000 55aa55aa 00000000 0
cpu 0 2 0 10000000 00000000 1122ee44 0
cpu 0 2 0 10000000 00000000 55aa55aa 0
dma 0 2 0 30000000 00000000 00000000 1
dma 0 2 0 10000004 00000000 beefc7d8 0
